/* Bender.yml */
package:
  name: armCore

sources:
  - files:
      - common/armPkg.sv
      - common/ctrlIf.sv
      - hw/datapath/regFile.sv
      - hw/datapath/armAlu.sv
      - hw/datapath/armDatapath.sv
      - hw/control/armDecoder.sv
      - hw/control/condUnit.sv
      - hw/armCore.sv
  - target: simulation
    files:
      - sim/armChecker.sv
      - sim/armCore_sva.sv
      - sim/armCoreTb.sv

/* common/armPkg.sv */
/*
 * ARM core package
 * Word, register, flag, condition and control types shared by the
 * single-cycle ARMv4 subset core and its testbench
 */
package armPkg;

   typedef logic [31:0] word_t;      // Data, address and instruction word
   typedef logic [3:0]  regAddr_t;

   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } flags_t;

   // Condition field encodings, instr[31:28]
   typedef enum logic [3:0] {
      EQ, NE, CS, CC, MI, PL, VS, VC,
      HI, LS, GE, LT, GT, LE, AL
   } cond_e;

   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,
      ALU_AND = 2'b10,
      ALU_ORR = 2'b11
   } aluOp_e;

   typedef enum logic [1:0] {
      IMM8     = 2'b00,   // Data processing, zero extended
      IMM12    = 2'b01,   // Load/store offset, zero extended
      BRANCH24 = 2'b10    // Sign extended, word offset
   } immSrc_e;

   localparam regAddr_t PC_REG  = 4'd15;
   localparam word_t    PC_STEP = 32'd4;

   // Major opcode, instr[27:26]
   localparam logic [1:0] OP_DP     = 2'b00;
   localparam logic [1:0] OP_MEM    = 2'b01;
   localparam logic [1:0] OP_BRANCH = 2'b10;

endpackage

/* common/ctrlIf.sv */
/*
 * Control bundle of the core
 * Raw controls from the decoder, gated writes from the condition unit
 */
`timescale 1ns/1ps

interface ctrlIf import armPkg::*; ();

   logic [1:0] regSrc;     // [0] first read is r15, [1] second read is Rd
   immSrc_e    immSrc;
   logic       aluSrc;     // Immediate as second operand
   aluOp_e     aluControl;
   logic       memtoReg;
   logic [1:0] flagW;      // [1] N/Z, [0] C/V
   logic       pcs;
   logic       regW;
   logic       memW;
   logic       regWrite;   // Condition passed
   logic       pcSrc;

   modport dec (output regSrc, immSrc, aluSrc, aluControl, memtoReg, flagW, pcs, regW, memW);
   modport cond (input flagW, pcs, regW, memW, output regWrite, pcSrc);
   modport dp (input regSrc, immSrc, aluSrc, aluControl, memtoReg, regWrite, pcSrc);

endinterface

/* hw/armCore.sv */
/*
 * ARM core top level
 * Single-cycle ARMv4 subset, decoder and condition unit around the datapath
 */
`timescale 1ns/1ps

module armCore import armPkg::*; (
   input  logic  clk,
   input  logic  reset,
   output word_t pc,
   input  word_t instr,
   output logic  memWrite,
   output word_t dataAdr,
   output word_t writeData,
   input  word_t readData
);

   flags_t aluFlags;

   ctrlIf ctl ();

   armDecoder dec (
      .instr (instr),
      .ctl   (ctl.dec)
   );

   condUnit cu (
      .clk      (clk),
      .reset    (reset),
      .cond     (cond_e'(instr[31:28])),
      .aluFlags (aluFlags),
      .ctl      (ctl.cond),
      .memWrite (memWrite)
   );

   armDatapath dp (
      .clk       (clk),
      .reset     (reset),
      .ctl       (ctl.dp),
      .instr     (instr),
      .aluFlags  (aluFlags),
      .pc        (pc),
      .dataAdr   (dataAdr),
      .writeData (writeData),
      .readData  (readData)
   );

endmodule

/* hw/control/armDecoder.sv */
/*
 * Instruction decoder
 * Main decoder and ALU decoder, instruction fields to raw controls
 */
`timescale 1ns/1ps

module armDecoder import armPkg::*; (
   input  word_t instr,
   ctrlIf.dec    ctl
);

   // Data processing cmd field, instr[24:21]
   localparam logic [3:0] FN_AND = 4'b0000;
   localparam logic [3:0] FN_SUB = 4'b0010;
   localparam logic [3:0] FN_ADD = 4'b0100;
   localparam logic [3:0] FN_ORR = 4'b1100;

   logic [1:0] op;
   logic [5:0] funct;          // I, cmd, S
   regAddr_t   rd;
   logic       aluOp;
   logic       dpValid;
   logic       branch;

   assign op    = instr[27:26];
   assign funct = instr[25:20];
   assign rd    = instr[15:12];
   assign aluOp = (op == OP_DP);

   // Main decoder
   always_comb begin
      ctl.regSrc   = 2'b00;
      ctl.immSrc   = IMM8;
      ctl.aluSrc   = 1'b0;
      ctl.memtoReg = 1'b0;
      ctl.regW     = 1'b0;
      ctl.memW     = 1'b0;
      branch       = 1'b0;
      case (op)
         OP_DP: begin
            ctl.aluSrc = funct[5];
            ctl.regW   = dpValid;
         end
         OP_MEM: if (!funct[5]) begin   // Immediate offset only
            ctl.immSrc = IMM12;
            ctl.aluSrc = 1'b1;
            if (funct[0]) begin            // LDR
               ctl.memtoReg = 1'b1;
               ctl.regW     = 1'b1;
            end else begin                 // STR reads Rd as data
               ctl.regSrc = 2'b10;
               ctl.memW   = 1'b1;
            end
         end
         OP_BRANCH: if (funct[5] && !funct[4]) begin   // B, no link
            ctl.regSrc = 2'b01;
            ctl.immSrc = BRANCH24;
            ctl.aluSrc = 1'b1;
            branch     = 1'b1;
         end
         default: ;
      endcase
   end

   // ALU decoder
   always_comb begin
      dpValid = 1'b1;
      case (funct[4:1])
         FN_ADD:  ctl.aluControl = ALU_ADD;
         FN_SUB:  ctl.aluControl = ALU_SUB;
         FN_AND:  ctl.aluControl = ALU_AND;
         FN_ORR:  ctl.aluControl = ALU_ORR;
         default: begin
            ctl.aluControl = ALU_ADD;
            dpValid        = 1'b0;
         end
      endcase
      if (!aluOp)
         ctl.aluControl = ALU_ADD;   // Address and branch target
   end

   // S bit; C/V only from arithmetic
   assign ctl.flagW[1] = aluOp & dpValid & funct[0];
   assign ctl.flagW[0] = ctl.flagW[1] &
                         (ctl.aluControl == ALU_ADD || ctl.aluControl == ALU_SUB);

   assign ctl.pcs = (ctl.regW && rd == PC_REG) || branch;

endmodule

/* hw/control/condUnit.sv */
/*
 * Condition unit
 * Stored N/Z and C/V flags, condition check, gating of all writes
 */
`timescale 1ns/1ps

module condUnit import armPkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  cond_e  cond,
   input  flags_t aluFlags,
   ctrlIf.cond    ctl,
   output logic   memWrite
);

   flags_t     flags;
   logic       condEx;
   logic       exec;
   logic [1:0] flagWrite;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else begin
         if (flagWrite[1]) begin
            flags.neg  <= aluFlags.neg;
            flags.zero <= aluFlags.zero;
         end
         if (flagWrite[0]) begin
            flags.carry    <= aluFlags.carry;
            flags.overflow <= aluFlags.overflow;
         end
      end
   end

   always_comb begin
      case (cond)
         EQ:      condEx = flags.zero;
         NE:      condEx = !flags.zero;
         CS:      condEx = flags.carry;
         CC:      condEx = !flags.carry;
         MI:      condEx = flags.neg;
         PL:      condEx = !flags.neg;
         VS:      condEx = flags.overflow;
         VC:      condEx = !flags.overflow;
         HI:      condEx = flags.carry && !flags.zero;
         LS:      condEx = !flags.carry || flags.zero;
         GE:      condEx = (flags.neg == flags.overflow);
         LT:      condEx = (flags.neg != flags.overflow);
         GT:      condEx = !flags.zero && (flags.neg == flags.overflow);
         LE:      condEx = flags.zero || (flags.neg != flags.overflow);
         AL:      condEx = 1'b1;
         default: condEx = 1'b0;   // 1111 is not supported
      endcase
   end

   assign exec = condEx & ~reset;

   assign flagWrite    = ctl.flagW & {2{exec}};
   assign ctl.regWrite = ctl.regW & exec;
   assign ctl.pcSrc    = ctl.pcs & exec;
   assign memWrite     = ctl.memW & exec;

endmodule

/* hw/datapath/armAlu.sv */
/*
 * ALU
 * Add, subtract, AND and OR with N, Z, C and V generation
 */
`timescale 1ns/1ps

module armAlu import armPkg::*; (
   input  word_t  a,
   input  word_t  b,
   input  aluOp_e aluControl,
   output word_t  result,
   output flags_t flags
);

   logic        sub;
   logic        arith;
   word_t       bInv;
   logic [32:0] sum;

   assign sub   = (aluControl == ALU_SUB);
   assign arith = (aluControl == ALU_ADD) || sub;
   assign bInv  = sub ? ~b : b;
   assign sum   = {1'b0, a} + {1'b0, bInv} + {32'b0, sub};   // Carry-in completes ~b + 1

   always_comb begin
      case (aluControl)
         ALU_AND: result = a & b;
         ALU_ORR: result = a | b;
         default: result = sum[31:0];
      endcase
   end

   assign flags.neg      = result[31];
   assign flags.zero     = (result == '0);
   assign flags.carry    = arith & sum[32];   // Borrow is inverted carry on SUB
   // Operands of equal effective sign, result of the other
   assign flags.overflow = arith & ~(a[31] ^ b[31] ^ sub) & (a[31] ^ sum[31]);

endmodule

/* hw/datapath/armDatapath.sv */
/*
 * Datapath
 * PC register, register file, operand selection, ALU and result mux
 */
`timescale 1ns/1ps

module armDatapath import armPkg::*; (
   input  logic   clk,
   input  logic   reset,
   ctrlIf.dp      ctl,
   input  word_t  instr,
   output flags_t aluFlags,
   output word_t  pc,
   output word_t  dataAdr,
   output word_t  writeData,
   input  word_t  readData
);

   word_t    pcPlus4;
   word_t    pcPlus8;
   word_t    pcNext;
   word_t    extImm;
   word_t    srcA;
   word_t    srcB;
   word_t    result;
   regAddr_t ra1;
   regAddr_t ra2;

   assign pcPlus4 = pc + PC_STEP;
   assign pcPlus8 = pcPlus4 + PC_STEP;   // r15 as seen by the program
   assign pcNext  = ctl.pcSrc ? result : pcPlus4;

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         pc <= '0;
      else
         pc <= pcNext;
   end

   assign ra1 = ctl.regSrc[0] ? PC_REG : instr[19:16];   // Rn or r15
   assign ra2 = ctl.regSrc[1] ? instr[15:12] : instr[3:0];   // Rd for STR

   regFile rf (
      .clk (clk),
      .we  (ctl.regWrite),
      .ra1 (ra1),
      .ra2 (ra2),
      .wa  (instr[15:12]),
      .wd  (result),
      .r15 (pcPlus8),
      .rd1 (srcA),
      .rd2 (writeData)
   );

   always_comb begin
      case (ctl.immSrc)
         IMM8:     extImm = {24'b0, instr[7:0]};
         IMM12:    extImm = {20'b0, instr[11:0]};
         BRANCH24: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
         default:  extImm = '0;
      endcase
   end

   assign srcB = ctl.aluSrc ? extImm : writeData;   // Register operand is unshifted

   armAlu alu (
      .a          (srcA),
      .b          (srcB),
      .aluControl (ctl.aluControl),
      .result     (dataAdr),
      .flags      (aluFlags)
   );

   assign result = ctl.memtoReg ? readData : dataAdr;

endmodule

/* hw/datapath/regFile.sv */
/*
 * Register file
 * r0 to r14 in flops, two combinational reads, r15 reads as PC plus 8
 */
`timescale 1ns/1ps

module regFile import armPkg::*; (
   input  logic     clk,
   input  logic     we,
   input  regAddr_t ra1,
   input  regAddr_t ra2,
   input  regAddr_t wa,
   input  word_t    wd,
   input  word_t    r15,
   output word_t    rd1,
   output word_t    rd2
);

   word_t regs [0:14];

   always_ff @(posedge clk) begin
      if (we && wa != PC_REG)   // PC write goes through pcSrc
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == PC_REG) ? r15 : regs[ra1];
   assign rd2 = (ra2 == PC_REG) ? r15 : regs[ra2];

endmodule

/* sim/armChecker.sv */
/*
 * Checker for the ARM core
 * Instruction-set reference model, per-cycle comparison, per-test report
 */
`timescale 1ns/1ps

module armChecker import armPkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  word_t pc,
   input  word_t instr,
   input  logic  memWrite,
   input  word_t dataAdr,
   input  word_t writeData,
   input  word_t readData,
   input  logic  testDone,
   input  int    testNum,
   output int    checkCount,
   output int    errorCount
);

   word_t  mRegs [0:14];
   word_t  mPc;
   flags_t mFlags;
   logic   expStore, expLoad;
   word_t  expAdr, expData;
   int     testChecks, testErrors;

   initial begin
      checkCount = 0;
      errorCount = 0;
      testChecks = 0;
      testErrors = 0;
   end

   function automatic logic condPass(input logic [3:0] c, input flags_t f);
      case (c)
         4'h0: return f.zero;
         4'h1: return !f.zero;
         4'h2: return f.carry;
         4'h3: return !f.carry;
         4'h4: return f.neg;
         4'h5: return !f.neg;
         4'h6: return f.overflow;
         4'h7: return !f.overflow;
         4'h8: return f.carry && !f.zero;
         4'h9: return !f.carry || f.zero;
         4'hA: return f.neg == f.overflow;
         4'hB: return f.neg != f.overflow;
         4'hC: return !f.zero && (f.neg == f.overflow);
         4'hD: return f.zero || (f.neg != f.overflow);
         4'hE: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic word_t readReg(input regAddr_t r);
      return (r == 4'd15) ? mPc + 8 : mRegs[r];
   endfunction

   // Executes one instruction on the model and sets the expected memory access
   function automatic void execute(input word_t ins, input word_t memData);
      word_t    a, b, res, nextPc;
      logic     carry, ovf, valid;
      regAddr_t rd;
      rd       = ins[15:12];
      nextPc   = mPc + 4;
      expStore = 1'b0;
      expLoad  = 1'b0;
      if (condPass(ins[31:28], mFlags)) begin
         case (ins[27:26])
            OP_DP: begin
               a     = readReg(ins[19:16]);
               b     = ins[25] ? {24'b0, ins[7:0]} : readReg(ins[3:0]);
               valid = 1'b1;
               carry = mFlags.carry;
               ovf   = mFlags.overflow;
               case (ins[24:21])
                  4'b0100: begin
                     {carry, res} = {1'b0, a} + {1'b0, b};
                     ovf = (a[31] == b[31]) && (res[31] != a[31]);
                  end
                  4'b0010: begin
                     res   = a - b;
                     carry = (a >= b);   // No borrow
                     ovf   = (a[31] != b[31]) && (res[31] != a[31]);
                  end
                  4'b0000: res = a & b;
                  4'b1100: res = a | b;
                  default: valid = 1'b0;
               endcase
               if (valid && ins[20])
                  mFlags = {res[31], (res == '0), carry, ovf};
               if (valid && rd == 4'd15)
                  nextPc = res;
               else if (valid)
                  mRegs[rd] = res;
            end
            OP_MEM: if (!ins[25]) begin
               expAdr = readReg(ins[19:16]) + {20'b0, ins[11:0]};
               if (ins[20]) begin
                  expLoad = 1'b1;
                  if (rd == 4'd15)
                     nextPc = memData;
                  else
                     mRegs[rd] = memData;
               end else begin
                  expStore = 1'b1;
                  expData  = readReg(rd);
               end
            end
            OP_BRANCH: if (ins[25:24] == 2'b10)
               nextPc = mPc + 8 + {{6{ins[23]}}, ins[23:0], 2'b00};
            default: ;
         endcase
      end
      mPc = nextPc;
   endfunction

   task automatic checkValue(input string name, input word_t got, input word_t exp);
      checkCount++;
      testChecks++;
      if (got !== exp) begin
         errorCount++;
         testErrors++;
         $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Mid-cycle compare with all DUT outputs and memory answers settled
   always @(negedge clk) begin
      if (reset) begin
         mPc    = '0;
         mFlags = '0;
      end else begin
         checkValue("pc", pc, mPc);
         execute(instr, readData);
         checkValue("memWrite", {31'b0, memWrite}, {31'b0, expStore});
         if (expStore || expLoad)
            checkValue("dataAdr", dataAdr, expAdr);
         if (expStore)
            checkValue("writeData", writeData, expData);
      end
   end

   always @(posedge testDone) begin
      $display("test %0d: %0d checks, %0d errors, %s", testNum, testChecks, testErrors,
               (testErrors == 0) ? "ok" : "failed");
      testChecks = 0;
      testErrors = 0;
   end

endmodule

/* sim/armCoreTb.sv */
/*
 * Testbench top for the ARM core
 * Clock, reset, instruction and data memories, test programs, watchdog
 */
`timescale 1ns/1ps

module armCoreTb import armPkg::*; ();

   localparam int NUM_TESTS = 5;
   // Data processing cmd field values
   localparam logic [3:0]  CMD_ADD  = 4'b0100;
   localparam logic [3:0]  CMD_SUB  = 4'b0010;
   localparam logic [3:0]  CMD_AND  = 4'b0000;
   localparam logic [3:0]  CMD_ORR  = 4'b1100;
   localparam logic [15:0] CMD_LIST = {CMD_ORR, CMD_AND, CMD_SUB, CMD_ADD};   // ADD lowest

   logic clk = 1'b0;
   logic reset;
   word_t pc, instr, dataAdr, writeData, readData;
   logic memWrite;
   logic testDone;
   int testNum, checkCount, errorCount;

   word_t imem [0:1023];
   word_t dmem [0:255];
   word_t progs [1:NUM_TESTS][0:1023];
   int progLens [1:NUM_TESTS];
   int curTest;
   logic [15:0] lfsr;
   logic loadTick = 1'b0;
   logic storeTick = 1'b0;
   int budgetNs;
   logic budgetReady = 1'b0;

   always #4 clk = ~clk;

   armCore dut (
      .clk (clk), .reset (reset), .pc (pc), .instr (instr), .memWrite (memWrite),
      .dataAdr (dataAdr), .writeData (writeData), .readData (readData)
   );

   armChecker chk (
      .clk (clk), .reset (reset), .pc (pc), .instr (instr), .memWrite (memWrite),
      .dataAdr (dataAdr), .writeData (writeData), .readData (readData),
      .testDone (testDone), .testNum (testNum),
      .checkCount (checkCount), .errorCount (errorCount)
   );

   // Memories answer 1 ns after their address moves
   always @(pc or loadTick) instr <= #1 imem[pc[11:2]];
   always @(dataAdr or storeTick) readData <= #1 dmem[dataAdr[9:2]];

   always @(posedge clk) begin
      if (memWrite) begin
         dmem[dataAdr[9:2]] <= writeData;
         storeTick          <= ~storeTick;
      end
   end

   function automatic word_t fillWord(input word_t addr);
      return {~addr[15:0], addr[15:0]} ^ (addr * 32'h9E37_79B1);
   endfunction

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic word_t randBits(input int n);
      word_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[15]};
         lfsr = lfsrNext(lfsr);
      end
      return v;
   endfunction

   // Instruction encoders
   function automatic word_t dp(input logic [3:0] c, input logic [3:0] cmd, input logic s,
                                input logic imm, input regAddr_t rn, input regAddr_t rd,
                                input logic [7:0] op2);
      return {c, 2'b00, imm, cmd, s, rn, rd, 4'b0000, op2};   // op2 is imm8 or {0, Rm}
   endfunction

   function automatic word_t mem(input logic [3:0] c, input logic ld, input regAddr_t rn,
                                 input regAddr_t rd, input logic [11:0] off);
      return {c, 2'b01, 1'b0, 2'b11, 2'b00, ld, rn, rd, off};   // P=1 U=1 and no writeback
   endfunction

   function automatic word_t br(input logic [3:0] c, input int off);
      return {c, 4'b1010, off[23:0]};
   endfunction

   task automatic emit(input word_t ins);
      progs[curTest][progLens[curTest]] = ins;
      progLens[curTest]++;
   endtask

   task automatic store(input regAddr_t rd, input logic [11:0] off);
      emit(mem(AL, 1'b0, 4'd0, rd, off));
   endtask

   // Byte by byte with eight doublings per byte
   task automatic loadWord(input regAddr_t rd, input word_t v);
      emit(dp(AL, CMD_ADD, 1'b0, 1'b1, 4'd0, rd, v[31:24]));
      for (int k = 2; k >= 0; k--) begin
         repeat (8) emit(dp(AL, CMD_ADD, 1'b0, 1'b0, rd, rd, {4'b0, rd}));
         emit(dp(AL, CMD_ORR, 1'b0, 1'b1, rd, rd, v[8*k +: 8]));
      end
   endtask

   task automatic condStores(input regAddr_t rd, input logic [11:0] base);
      for (int c = 0; c < 15; c++)
         emit(mem(c, 1'b0, 4'd0, rd, base + 4 * c));
   endtask

   task automatic buildProgram(input int t);
      word_t a;
      word_t b;
      curTest     = t;
      progLens[t] = 0;
      emit(dp(AL, CMD_AND, 1'b0, 1'b1, 4'd0, 4'd0, 8'h00));   // r0 = 0
      case (t)
         1: begin   // ALU with register and immediate operands
            for (int r = 1; r <= 3; r++)
               loadWord(r, randBits(32));
            for (int k = 0; k < 4; k++) begin
               emit(dp(AL, CMD_LIST[4*k +: 4], 1'b0, 1'b0, 4'd1, 4'd5, 8'd2));
               store(5, 12'h100 + 16 * k);
               emit(dp(AL, CMD_LIST[4*k +: 4], 1'b0, 1'b1, 4'd3, 4'd6, 8'(randBits(8))));
               store(6, 12'h104 + 16 * k);
               emit(dp(AL, CMD_LIST[4*k +: 4], 1'b0, 1'b0, 4'd2, 4'd7, 8'd3));
               store(7, 12'h108 + 16 * k);
            end
         end
         2: begin   // LDR then STR of the loaded word
            for (int k = 0; k < 4; k++) begin
               emit(dp(AL, CMD_ADD, 1'b0, 1'b1, 4'd0, 4'd9, {6'(randBits(6)), 2'b00}));
               emit(mem(AL, 1'b1, 4'd9, 4'd8, {4'b0, 6'(randBits(6)), 2'b00}));
               store(8, 12'h200 + 4 * k);
            end
         end
         3: begin   // Condition codes after ADDS/SUBS and after ANDS
            for (int p = 0; p < 4; p++) begin
               a = randBits(32);
               b = randBits(32);
               if (p == 3) begin   // Two positives that overflow
                  a[31:30] = 2'b01;
                  b[31:30] = 2'b01;
               end
               loadWord(1, a);
               loadWord(2, b);
               emit(dp(AL, (p == 1 || p == 2) ? CMD_SUB : CMD_ADD, 1'b1, 1'b0, 4'd1, 4'd3,
                       (p == 2) ? 8'd1 : 8'd2));
               condStores(3, 12'h300);
               emit(dp(AL, CMD_AND, 1'b1, 1'b0, 4'd1, 4'd4, 8'd2));
               condStores(4, 12'h340);
            end
         end
         4: begin   // Conditional branches over a store and a backward branch
            loadWord(1, randBits(32));
            loadWord(2, randBits(32));
            emit(dp(AL, CMD_SUB, 1'b1, 1'b0, 4'd1, 4'd3, 8'd2));
            for (int c = 0; c < 15; c++) begin
               emit(br(c, 0));
               store(3, 12'h380 + 4 * c);
            end
            emit(br(AL, 1));
            store(1, 12'h3C0);
            emit(br(AL, 0));
            emit(br(AL, -4));
         end
         default: begin   // r15 as source and as destination
            emit(dp(AL, CMD_ADD, 1'b0, 1'b1, 4'd15, 4'd5, 8'd0));
            store(5, 12'h3D0);
            emit(dp(AL, CMD_ADD, 1'b0, 1'b0, 4'd0, 4'd7, 8'd15));
            store(7, 12'h3D4);
            store(15, 12'h3D8);
            emit(dp(AL, CMD_ADD, 1'b0, 1'b1, 4'd15, 4'd15, 8'd4));   // Skips two
            store(5, 12'h3DC);
            store(5, 12'h3DC);
            emit(dp(AL, CMD_ADD, 1'b0, 1'b1, 4'd0, 4'd15, 8'(4 * (progLens[t] + 2))));
            store(7, 12'h3E0);
         end
      endcase
      emit(br(AL, -2));   // Halt loop
   endtask

   task automatic runProgram(input int t);
      @(posedge clk);
      #1 reset = 1'b1;
      testNum = t;
      for (int i = 0; i < 1024; i++)
         imem[i] = (i < progLens[t]) ? progs[t][i] : '0;
      loadTick = ~loadTick;
      repeat (4) @(posedge clk);
      #1 reset = 1'b0;
      wait (pc == 4 * (progLens[t] - 1));
      repeat (2) @(posedge clk);
      #1 testDone = 1'b1;
      @(posedge clk);
      #1 testDone = 1'b0;
   endtask

   initial begin
      reset    = 1'b1;
      instr    = '0;
      readData = '0;
      testDone = 1'b0;
      testNum  = 0;
      lfsr     = 16'd31863;
      budgetNs = 50 * 8;
      for (int i = 0; i < 256; i++)
         dmem[i] = fillWord(4 * i);
      for (int t = 1; t <= NUM_TESTS; t++) begin
         buildProgram(t);
         budgetNs += (progLens[t] + 8) * 8;   // Reset and done handshake included
      end
      budgetReady = 1'b1;
      for (int t = 1; t <= NUM_TESTS; t++)
         runProgram(t);
      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", NUM_TESTS,
               checkCount, errorCount, dut.sva.assertFails);
      if (errorCount == 0 && dut.sva.assertFails == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      wait (budgetReady);
      #(budgetNs);
      $display("timeout: a program did not reach its halt loop within %0d ns", budgetNs);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

/* sim/armCore_sva.sv */
/*
 * Assertions for the ARM core
 * Store gating in reset, pc timing and pc alignment
 */
`timescale 1ns/1ps

module armCore_sva import armPkg::*; (
   input logic  clk,
   input logic  reset,
   input word_t pc,
   input logic  memWrite
);

   word_t pcRise;
   word_t pcFall;
   int    assertFails = 0;   // Read by the testbench at the end of the run

   // Snapshots of pc just after each rising edge and at each falling edge
   always @(posedge clk) #1 pcRise <= pc;
   always @(negedge clk) pcFall <= pc;

   noStoreInReset: assert property (@(negedge clk) reset |-> !memWrite)
      else begin
         assertFails++;
         $error("memWrite high while reset is asserted");
      end

   pcSteadyHigh: assert property (@(negedge clk) disable iff (reset) pc == pcRise)
      else begin
         assertFails++;
         $error("pc changed during the high phase of clk");
      end

   pcSteadyLow: assert property (@(posedge clk) disable iff (reset) pc == pcFall)
      else begin
         assertFails++;
         $error("pc changed during the low phase of clk");
      end

   pcAligned: assert property (@(negedge clk) pc[1:0] == 2'b00)
      else begin
         assertFails++;
         $error("pc is not word aligned");
      end

endmodule

bind armCore armCore_sva sva (
   .clk      (clk),
   .reset    (reset),
   .pc       (pc),
   .memWrite (memWrite)
);

/* src.f */
common/armPkg.sv
common/ctrlIf.sv
hw/datapath/regFile.sv
hw/datapath/armAlu.sv
hw/datapath/armDatapath.sv
hw/control/armDecoder.sv
hw/control/condUnit.sv
hw/armCore.sv
sim/armChecker.sv
sim/armCore_sva.sv
sim/armCoreTb.sv
